// ==== project.f ====
fb_pkg.sv
buffer_manager.sv
frame_writer.sv
frame_reader.sv
mem_cmd_arbiter.sv
frame_buffer_ctrl.sv
tb_frame_buffer_ctrl.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_buffer_ctrl \
		-f project.f -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== tb_frame_buffer_ctrl.sv ====
module tb_frame_buffer_ctrl;

    localparam logic [31:0] LFSR_SEED = 32'hfc01ab2a;
    localparam logic [31:0] LFSR_POLY = 32'h80200003;
    localparam int          WORDS     = 32;

    logic           clk;
    logic           rst_n;
    logic           init_done_i;
    logic           pix_valid_i;
    fb_pkg::pixel_t pix_data_i;
    logic           pix_ready_o;
    logic           out_valid_o;
    fb_pkg::pixel_t out_data_o;
    logic           out_ready_i;
    logic           cmd_en_o;
    logic           cmd_o;
    logic [20:0]    addr_o;
    fb_pkg::pixel_t wr_data_o;
    logic           cmd_ready_i;
    fb_pkg::pixel_t rd_data_i;
    logic           rd_data_valid_i;

    // memory model and scoreboard state
    logic [31:0] mem [128];
    logic [31:0] lfsr;
    logic [31:0] bits;
    logic [31:0] pix_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] ret_q [$];
    int          due_q [$];
    logic        region_whole [4];
    logic        region_written [4];
    int cyc, init_cycles, ret_delay;
    int wr_n, wr_base, wr_frames;
    int rd_n, rd_base, rd_region, sink_n, sink_frames;
    int mismatch_errs, other_errs;
    logic pix_taken, rd_busy;
    logic pix_en, pix_gaps, out_en, out_gaps, cmd_gaps;

    frame_buffer_ctrl #(
        .FRAME_WIDTH  (8),
        .FRAME_HEIGHT (4),
        .INIT_DELAY   (10),
        .RD_FIFO_DEPTH(4)
    ) uut (
        .clk(clk), .rst_n(rst_n), .init_done_i(init_done_i),
        .pix_valid_i(pix_valid_i), .pix_data_i(pix_data_i), .pix_ready_o(pix_ready_o),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_ready_i(out_ready_i),
        .cmd_en_o(cmd_en_o), .cmd_o(cmd_o), .addr_o(addr_o), .wr_data_o(wr_data_o),
        .cmd_ready_i(cmd_ready_i), .rd_data_i(rd_data_i), .rd_data_valid_i(rd_data_valid_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_write();
        logic [31:0] exp;
        if (wr_n == 0) begin
            wr_base = int'(addr_o);
            assert (addr_o % WORDS == 0 && addr_o < 3 * WORDS) else begin
                other_errs++;
                $display("write frame at %0t starts at %0d, off a buffer base", $time, addr_o);
            end
            region_whole[addr_o[6:5]] = 1'b0;
        end else begin
            assert (int'(addr_o) == wr_base + wr_n) else begin
                mismatch_errs++;
                $display("Mismatch at %0t: addr_o = %0d, expected %0d", $time, addr_o,
                         wr_base + wr_n);
            end
        end
        assert (!(rd_busy && addr_o[6:5] == rd_region[1:0])) else begin
            other_errs++;
            $display("write at %0t hits the buffer that is being read", $time);
        end
        assert (pix_q.size() > 0) else begin
            other_errs++;
            $display("write at %0t has no accepted pixel behind it", $time);
        end
        if (pix_q.size() > 0) begin
            exp = pix_q.pop_front();
            assert (wr_data_o == exp) else begin
                mismatch_errs++;
                $display("Mismatch at %0t: wr_data_o = %h, expected %h", $time, wr_data_o, exp);
            end
        end
        mem[addr_o[6:0]] = wr_data_o;
        wr_n++;
        if (wr_n == WORDS) begin
            wr_n = 0;
            region_whole[addr_o[6:5]]   = 1'b1;
            region_written[addr_o[6:5]] = 1'b1;
            wr_frames++;
        end
    endtask

    task automatic take_read();
        if (rd_n == 0) begin
            rd_base   = int'(addr_o);
            rd_region = int'(addr_o[6:5]);
            rd_busy   = 1'b1;
            assert (addr_o % WORDS == 0 && addr_o < 3 * WORDS) else begin
                other_errs++;
                $display("read frame at %0t starts at %0d, off a buffer base", $time, addr_o);
            end
            assert (!region_written[rd_region] || region_whole[rd_region]) else begin
                other_errs++;
                $display("read frame at %0t starts on a partly written buffer", $time);
            end
        end else begin
            assert (int'(addr_o) == rd_base + rd_n) else begin
                mismatch_errs++;
                $display("Mismatch at %0t: addr_o = %0d, expected %0d", $time, addr_o,
                         rd_base + rd_n);
            end
        end
        exp_q.push_back(mem[addr_o[6:0]]);
        ret_q.push_back(mem[addr_o[6:0]]);
        due_q.push_back(cyc + ret_delay);
        rd_n = (rd_n + 1) % WORDS;
    endtask

    task automatic check_sink();
        logic [31:0] exp;
        assert (exp_q.size() > 0) else begin
            other_errs++;
            $display("sink word at %0t without a read behind it", $time);
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (out_data_o == exp) else begin
                mismatch_errs++;
                $display("Mismatch at %0t: out_data_o = %h, expected %h", $time, out_data_o, exp);
            end
        end
        sink_n++;
        if (sink_n == WORDS) begin
            sink_n  = 0;
            rd_busy = 1'b0;
            sink_frames++;
        end
    endtask

    // sample transfers on the rising edge
    always @(posedge clk) begin
        cyc++;
        pix_taken = 1'b0;
        if (rst_n) begin
            assert (!cmd_en_o || init_cycles >= 10) else begin
                other_errs++;
                $display("command at %0t before the start-up wait ended", $time);
            end
            if (init_done_i) begin
                init_cycles++;
            end
            if (pix_valid_i && pix_ready_o) begin
                pix_q.push_back(pix_data_i);
                pix_taken = 1'b1;
            end
            if (cmd_en_o && cmd_ready_i) begin
                if (cmd_o) begin
                    check_write();
                end else begin
                    take_read();
                end
            end
            if (out_valid_o && out_ready_i) begin
                check_sink();
            end
        end
    end

    // source, sink and memory model drive on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            take_bits(1, bits);
            cmd_ready_i = !cmd_gaps || bits[0];
            take_bits(1, bits);
            out_ready_i = out_en && (!out_gaps || bits[0]);
            if (!pix_valid_i || pix_taken) begin
                take_bits(1, bits);
                pix_valid_i = pix_en && (!pix_gaps || bits[0]);
                take_bits(32, bits);
                pix_data_i = bits;
            end
            take_bits(2, bits);
            ret_delay = int'(bits[1:0]);
            if (ret_q.size() > 0 && due_q[0] <= cyc) begin
                rd_data_valid_i = 1'b1;
                rd_data_i       = ret_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                rd_data_valid_i = 1'b0;
            end
        end
    end

    task automatic check_startup();
        int n;
        repeat (20) begin
            @(negedge clk);
            assert (!cmd_en_o && !out_valid_o) else begin
                mismatch_errs++;
                $display("Mismatch at %0t: cmd_en_o = %b, out_valid_o = %b, expected 0 and 0",
                         $time, cmd_en_o, out_valid_o);
            end
            assert (!pix_ready_o) else begin
                mismatch_errs++;
                $display("Mismatch at %0t: pix_ready_o = %b, expected 0", $time, pix_ready_o);
            end
        end
        init_done_i = 1'b1;
        n = 0;
        while (!cmd_en_o && n < 200) begin
            @(negedge clk);
            n++;
        end
        assert (cmd_en_o) else begin
            other_errs++;
            $display("timeout waiting for the first memory command");
        end
        assert (n >= 10) else begin
            other_errs++;
            $display("first command came %0d cycles after init_done_i", n);
        end
    endtask

    // reader sits on a full FIFO while two frames go in
    task automatic write_two_frames();
        int n;
        pix_en = 1'b1;
        n = 0;
        while (wr_frames < 2 && n < 1000) begin
            @(negedge clk);
            n++;
        end
        assert (wr_frames >= 2) else begin
            other_errs++;
            $display("timeout waiting for two written frames");
        end
        pix_en = 1'b0;
    endtask

    task automatic read_back_frames();
        int n;
        out_en = 1'b1;
        n = 0;
        while (sink_frames < 3 && n < 1000) begin
            @(negedge clk);
            n++;
        end
        assert (sink_frames >= 3) else begin
            other_errs++;
            $display("timeout waiting for three read frames");
        end
    endtask

    task automatic random_traffic();
        int n, w0, s0;
        w0 = wr_frames;
        s0 = sink_frames;
        {pix_gaps, out_gaps, cmd_gaps} = 3'b111;
        pix_en = 1'b1;
        n = 0;
        while ((wr_frames < w0 + 6 || sink_frames < s0 + 6) && n < 20000) begin
            @(negedge clk);
            n++;
        end
        assert (wr_frames >= w0 + 6 && sink_frames >= s0 + 6) else begin
            other_errs++;
            $display("timeout waiting for frames under random gaps");
        end
        pix_en = 1'b0;
    endtask

    task automatic drain_writer();
        int n;
        n = 0;
        while ((pix_valid_i || pix_q.size() > 0) && n < 500) begin
            @(negedge clk);
            n++;
        end
        assert (!pix_valid_i && pix_q.size() == 0) else begin
            other_errs++;
            $display("%0d accepted pixels were never written", pix_q.size());
        end
    endtask

    initial begin
        rst_n           = 1'b0;
        init_done_i     = 1'b0;
        pix_valid_i     = 1'b0;
        pix_data_i      = '0;
        out_ready_i     = 1'b0;
        cmd_ready_i     = 1'b0;
        rd_data_i       = '0;
        rd_data_valid_i = 1'b0;
        {pix_en, pix_gaps, out_en, out_gaps, cmd_gaps} = '0;
        {cyc, init_cycles, ret_delay, wr_n, wr_base, wr_frames} = '0;
        {rd_n, rd_base, rd_region, sink_n, sink_frames} = '0;
        {mismatch_errs, other_errs} = '0;
        pix_taken = 1'b0;
        rd_busy   = 1'b0;
        lfsr      = LFSR_SEED;
        for (int a = 0; a < 128; a++) begin
            mem[a] = 32'h5a000000 | a;
        end
        for (int r = 0; r < 4; r++) begin
            region_whole[r]   = 1'b0;
            region_written[r] = 1'b0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        check_startup();
        write_two_frames();
        read_back_frames();
        random_traffic();
        drain_writer();
        $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== frame_buffer_ctrl.sv ====
module frame_buffer_ctrl #(
    parameter int FRAME_WIDTH   = 640,
    parameter int FRAME_HEIGHT  = 480,
    parameter int INIT_DELAY    = 152,
    parameter int RD_FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              init_done_i,
    input  logic              pix_valid_i,
    input  fb_pkg::pixel_t    pix_data_i,
    output logic              pix_ready_o,
    output logic              out_valid_o,
    output fb_pkg::pixel_t    out_data_o,
    input  logic              out_ready_i,
    output logic              cmd_en_o,
    output logic              cmd_o,
    output fb_pkg::mem_addr_t addr_o,
    output fb_pkg::pixel_t    wr_data_o,
    input  logic              cmd_ready_i,
    input  fb_pkg::pixel_t    rd_data_i,
    input  logic              rd_data_valid_i
);

    logic              wr_lock_req;
    logic              rd_lock_req;
    logic              wr_lock_gnt;
    logic              rd_lock_gnt;
    fb_pkg::buf_idx_t  lock_idx;
    logic              wr_release;
    logic              rd_release;
    logic              wr_cmd_valid;
    fb_pkg::mem_addr_t wr_cmd_addr;
    fb_pkg::pixel_t    wr_cmd_data;
    logic              wr_cmd_ready;
    logic              rd_cmd_valid;
    fb_pkg::mem_addr_t rd_cmd_addr;
    logic              rd_cmd_ready;

    buffer_manager #(
        .INIT_DELAY(INIT_DELAY)
    ) u_buf_mgr (
        .clk          (clk),
        .rst_n        (rst_n),
        .init_done_i  (init_done_i),
        .wr_lock_req_i(wr_lock_req),
        .rd_lock_req_i(rd_lock_req),
        .wr_lock_gnt_o(wr_lock_gnt),
        .rd_lock_gnt_o(rd_lock_gnt),
        .lock_idx_o   (lock_idx),
        .wr_release_i (wr_release),
        .rd_release_i (rd_release)
    );

    frame_writer #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_lock_req_o (wr_lock_req),
        .wr_lock_gnt_i (wr_lock_gnt),
        .lock_idx_i    (lock_idx),
        .wr_release_o  (wr_release),
        .pix_valid_i   (pix_valid_i),
        .pix_data_i    (pix_data_i),
        .pix_ready_o   (pix_ready_o),
        .wr_cmd_valid_o(wr_cmd_valid),
        .wr_cmd_addr_o (wr_cmd_addr),
        .wr_cmd_data_o (wr_cmd_data),
        .wr_cmd_ready_i(wr_cmd_ready)
    );

    frame_reader #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .RD_FIFO_DEPTH(RD_FIFO_DEPTH)
    ) u_reader (
        .clk            (clk),
        .rst_n          (rst_n),
        .rd_lock_req_o  (rd_lock_req),
        .rd_lock_gnt_i  (rd_lock_gnt),
        .lock_idx_i     (lock_idx),
        .rd_release_o   (rd_release),
        .rd_cmd_valid_o (rd_cmd_valid),
        .rd_cmd_addr_o  (rd_cmd_addr),
        .rd_cmd_ready_i (rd_cmd_ready),
        .rd_data_i      (rd_data_i),
        .rd_data_valid_i(rd_data_valid_i),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .out_ready_i    (out_ready_i)
    );

    mem_cmd_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_cmd_valid_i(wr_cmd_valid),
        .wr_cmd_addr_i (wr_cmd_addr),
        .wr_cmd_data_i (wr_cmd_data),
        .wr_cmd_ready_o(wr_cmd_ready),
        .rd_cmd_valid_i(rd_cmd_valid),
        .rd_cmd_addr_i (rd_cmd_addr),
        .rd_cmd_ready_o(rd_cmd_ready),
        .cmd_en_o      (cmd_en_o),
        .cmd_o         (cmd_o),
        .addr_o        (addr_o),
        .wr_data_o     (wr_data_o),
        .cmd_ready_i   (cmd_ready_i)
    );

endmodule

// ==== mem_cmd_arbiter.sv ====
module mem_cmd_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_cmd_valid_i,
    input  fb_pkg::mem_addr_t wr_cmd_addr_i,
    input  fb_pkg::pixel_t    wr_cmd_data_i,
    output logic              wr_cmd_ready_o,
    input  logic              rd_cmd_valid_i,
    input  fb_pkg::mem_addr_t rd_cmd_addr_i,
    output logic              rd_cmd_ready_o,
    output logic              cmd_en_o,
    output logic              cmd_o,
    output fb_pkg::mem_addr_t addr_o,
    output fb_pkg::pixel_t    wr_data_o,
    input  logic              cmd_ready_i
);

    logic last_wr;
    logic stall_q;
    logic sel_wr;
    logic sel_rd;

    // a stalled command keeps its slot, otherwise take turns
    always_comb begin
        if (stall_q) begin
            sel_wr = last_wr;
        end else if (wr_cmd_valid_i && rd_cmd_valid_i) begin
            sel_wr = !last_wr;
        end else begin
            sel_wr = wr_cmd_valid_i;
        end
    end

    assign sel_rd         = rd_cmd_valid_i && !sel_wr;
    assign cmd_en_o       = wr_cmd_valid_i || rd_cmd_valid_i;
    assign cmd_o          = sel_wr;
    assign addr_o         = sel_wr ? wr_cmd_addr_i : (sel_rd ? rd_cmd_addr_i : '0);
    assign wr_data_o      = sel_wr ? wr_cmd_data_i : '0;
    assign wr_cmd_ready_o = sel_wr && cmd_ready_i;
    assign rd_cmd_ready_o = sel_rd && cmd_ready_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_wr <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            stall_q <= cmd_en_o && !cmd_ready_i;
            if (cmd_en_o) begin
                last_wr <= sel_wr;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_en_o && !cmd_ready_i) |=> (cmd_en_o && $stable(cmd_o) && $stable(addr_o)));

endmodule

// ==== frame_reader.sv ====
module frame_reader #(
    parameter int FRAME_WIDTH   = 640,
    parameter int FRAME_HEIGHT  = 480,
    parameter int RD_FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              rd_lock_req_o,
    input  logic              rd_lock_gnt_i,
    input  fb_pkg::buf_idx_t  lock_idx_i,
    output logic              rd_release_o,
    output logic              rd_cmd_valid_o,
    output fb_pkg::mem_addr_t rd_cmd_addr_o,
    input  logic              rd_cmd_ready_i,
    input  fb_pkg::pixel_t    rd_data_i,
    input  logic              rd_data_valid_i,
    output logic              out_valid_o,
    output fb_pkg::pixel_t    out_data_o,
    input  logic              out_ready_i
);

    localparam int FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int CNT_W       = $clog2(FRAME_WORDS + 1);
    localparam int PTR_W       = $clog2(RD_FIFO_DEPTH);
    localparam int OCC_W       = $clog2(RD_FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        ST_LOCK,
        ST_READ,
        ST_RELEASE
    } rd_state_t;

    rd_state_t         state;
    fb_pkg::mem_addr_t base;
    logic [CNT_W-1:0]  issue_cnt;
    logic [CNT_W-1:0]  out_cnt;
    logic [OCC_W-1:0]  inflight;
    logic [OCC_W-1:0]  fifo_cnt;
    logic [OCC_W:0]    occupancy;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    fb_pkg::pixel_t    fifo_mem [RD_FIFO_DEPTH];
    logic              rd_issue;
    logic              out_fire;
    logic              last_out;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(RD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // every outstanding read owns a fifo slot
    assign occupancy      = inflight + fifo_cnt;
    assign rd_lock_req_o  = (state == ST_LOCK);
    assign rd_release_o   = (state == ST_RELEASE);
    assign rd_cmd_valid_o = (state == ST_READ) && (issue_cnt != CNT_W'(FRAME_WORDS))
                            && (occupancy < (OCC_W + 1)'(RD_FIFO_DEPTH));
    assign rd_cmd_addr_o  = base + fb_pkg::mem_addr_t'(issue_cnt);
    assign rd_issue       = rd_cmd_valid_o && rd_cmd_ready_i;
    assign out_valid_o    = (fifo_cnt != '0);
    assign out_data_o     = fifo_mem[rd_ptr];
    assign out_fire       = out_valid_o && out_ready_i;
    assign last_out       = out_fire && (out_cnt == CNT_W'(FRAME_WORDS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_LOCK;
            issue_cnt <= '0;
            out_cnt   <= '0;
            inflight  <= '0;
            fifo_cnt  <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else begin
            case (state)
                ST_LOCK: begin
                    if (rd_lock_gnt_i) begin
                        state     <= ST_READ;
                        issue_cnt <= '0;
                        out_cnt   <= '0;
                    end
                end
                ST_READ: begin
                    if (last_out) begin
                        state <= ST_RELEASE;
                    end
                end
                default: state <= ST_LOCK;
            endcase
            if (rd_issue) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (out_fire) begin
                out_cnt <= out_cnt + 1'b1;
                rd_ptr  <= next_ptr(rd_ptr);
            end
            if (rd_data_valid_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            inflight <= inflight + OCC_W'(rd_issue) - OCC_W'(rd_data_valid_i);
            fifo_cnt <= fifo_cnt + OCC_W'(rd_data_valid_i) - OCC_W'(out_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOCK && rd_lock_gnt_i) begin
            base <= fb_pkg::mem_addr_t'(lock_idx_i * FRAME_WORDS);
        end
        if (rd_data_valid_i) begin
            fifo_mem[wr_ptr] <= rd_data_i;
        end
    end

    // returns have no back-pressure
    assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_valid_i |-> (fifo_cnt != OCC_W'(RD_FIFO_DEPTH)));

endmodule

// ==== frame_writer.sv ====
module frame_writer #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic              clk,
    input  logic              rst_n,
    output logic              wr_lock_req_o,
    input  logic              wr_lock_gnt_i,
    input  fb_pkg::buf_idx_t  lock_idx_i,
    output logic              wr_release_o,
    input  logic              pix_valid_i,
    input  fb_pkg::pixel_t    pix_data_i,
    output logic              pix_ready_o,
    output logic              wr_cmd_valid_o,
    output fb_pkg::mem_addr_t wr_cmd_addr_o,
    output fb_pkg::pixel_t    wr_cmd_data_o,
    input  logic              wr_cmd_ready_i
);

    localparam int FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int CNT_W       = $clog2(FRAME_WORDS + 1);

    typedef enum logic [1:0] {
        ST_LOCK,
        ST_WRITE,
        ST_RELEASE
    } wr_state_t;

    wr_state_t         state;
    fb_pkg::mem_addr_t base;
    logic [CNT_W-1:0]  acc_cnt;
    logic              pix_full;
    logic              pix_take;
    logic              cmd_fire;
    logic              frame_done;

    assign wr_lock_req_o  = (state == ST_LOCK);
    assign wr_release_o   = (state == ST_RELEASE);
    assign wr_cmd_valid_o = pix_full;
    assign cmd_fire       = pix_full && wr_cmd_ready_i;
    // one-entry register, refilled in the cycle it drains
    assign pix_ready_o    = (state == ST_WRITE) && (acc_cnt != CNT_W'(FRAME_WORDS))
                            && (!pix_full || wr_cmd_ready_i);
    assign pix_take       = pix_valid_i && pix_ready_o;
    assign frame_done     = cmd_fire && (acc_cnt == CNT_W'(FRAME_WORDS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_LOCK;
            acc_cnt  <= '0;
            pix_full <= 1'b0;
        end else begin
            case (state)
                ST_LOCK: begin
                    if (wr_lock_gnt_i) begin
                        state   <= ST_WRITE;
                        acc_cnt <= '0;
                    end
                end
                ST_WRITE: begin
                    if (frame_done) begin
                        state <= ST_RELEASE;
                    end
                end
                default: state <= ST_LOCK;
            endcase
            if (pix_take) begin
                pix_full <= 1'b1;
                acc_cnt  <= acc_cnt + 1'b1;
            end else if (cmd_fire) begin
                pix_full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOCK && wr_lock_gnt_i) begin
            base <= fb_pkg::mem_addr_t'(lock_idx_i * FRAME_WORDS);
        end
        if (pix_take) begin
            wr_cmd_data_o <= pix_data_i;
            wr_cmd_addr_o <= base + fb_pkg::mem_addr_t'(acc_cnt);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_cmd_valid_o && !wr_cmd_ready_i) |=> (wr_cmd_valid_o
            && $stable(wr_cmd_addr_o) && $stable(wr_cmd_data_o)));

endmodule

// ==== buffer_manager.sv ====
module buffer_manager #(
    parameter int INIT_DELAY = 10
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init_done_i,
    input  logic             wr_lock_req_i,
    input  logic             rd_lock_req_i,
    output logic             wr_lock_gnt_o,
    output logic             rd_lock_gnt_o,
    output fb_pkg::buf_idx_t lock_idx_o,
    input  logic             wr_release_i,
    input  logic             rd_release_i
);

    localparam int DLY_W = $clog2(INIT_DELAY + 1);

    logic [DLY_W-1:0]   dly_cnt;
    logic               mem_ready;
    fb_pkg::buf_state_t buf_state [fb_pkg::NUM_BUFFERS];
    logic               wr_held;
    logic               rd_held;
    fb_pkg::buf_idx_t   wr_idx;
    fb_pkg::buf_idx_t   rd_idx;
    logic [2:0]         wr_pick;
    logic [2:0]         rd_pick;
    logic               wr_take;
    logic               rd_take;

    // returns {found, idx}, lowest index of the first state that matches
    function automatic logic [2:0] pick_buf(input fb_pkg::buf_state_t p0,
                                            input fb_pkg::buf_state_t p1,
                                            input fb_pkg::buf_state_t p2);
        fb_pkg::buf_state_t pref [3];
        logic [2:0]         res;
        pref = '{p0, p1, p2};
        res  = '0;
        for (int p = 0; p < 3; p++) begin
            for (int b = 0; b < fb_pkg::NUM_BUFFERS; b++) begin
                if (!res[2] && buf_state[b] == pref[p]) begin
                    res = {1'b1, fb_pkg::buf_idx_t'(b)};
                end
            end
        end
        return res;
    endfunction

    assign mem_ready = (dly_cnt == DLY_W'(INIT_DELAY));

    // in-use buffers never match either preference list
    always_comb begin
        wr_pick = pick_buf(fb_pkg::BUF_DISPLAYED, fb_pkg::BUF_AVAILABLE, fb_pkg::BUF_UPDATED);
        rd_pick = pick_buf(fb_pkg::BUF_UPDATED, fb_pkg::BUF_AVAILABLE, fb_pkg::BUF_DISPLAYED);
        wr_take = mem_ready && wr_lock_req_i && !wr_held && wr_pick[2];
        rd_take = mem_ready && rd_lock_req_i && !rd_held && rd_pick[2] && !wr_take;
    end

    // cumulative, sticks once reached
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dly_cnt <= '0;
        end else if (init_done_i && !mem_ready) begin
            dly_cnt <= dly_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_lock_gnt_o <= 1'b0;
            rd_lock_gnt_o <= 1'b0;
            wr_held       <= 1'b0;
            rd_held       <= 1'b0;
            for (int b = 0; b < fb_pkg::NUM_BUFFERS; b++) begin
                buf_state[b] <= fb_pkg::BUF_AVAILABLE;
            end
        end else begin
            wr_lock_gnt_o <= wr_take;
            rd_lock_gnt_o <= rd_take;
            if (wr_release_i) begin
                wr_held           <= 1'b0;
                buf_state[wr_idx] <= fb_pkg::BUF_UPDATED;
            end
            if (rd_release_i) begin
                rd_held           <= 1'b0;
                buf_state[rd_idx] <= fb_pkg::BUF_DISPLAYED;
            end
            if (wr_take) begin
                wr_held                 <= 1'b1;
                buf_state[wr_pick[1:0]] <= fb_pkg::BUF_WRITING;
            end
            if (rd_take) begin
                rd_held                 <= 1'b1;
                buf_state[rd_pick[1:0]] <= fb_pkg::BUF_READING;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            wr_idx     <= wr_pick[1:0];
            lock_idx_o <= wr_pick[1:0];
        end else if (rd_take) begin
            rd_idx     <= rd_pick[1:0];
            lock_idx_o <= rd_pick[1:0];
        end
    end

    // writer and reader never share a frame
    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_held && rd_held) |-> (wr_idx != rd_idx));

endmodule

// ==== fb_pkg.sv ====
package fb_pkg;

    localparam int NUM_BUFFERS = 3;

    typedef logic [1:0] buf_idx_t;

    typedef enum logic [2:0] {
        BUF_AVAILABLE,
        BUF_WRITING,
        BUF_READING,
        BUF_DISPLAYED,
        BUF_UPDATED
    } buf_state_t;

    // memory word address
    localparam int MEM_ADDR_W = 21;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // one pixel per memory word
    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] pixel_t;

endpackage
